// ==== tile_pkg.sv ====
`default_nettype none

package tile_pkg;

    // Tile geometry.
    localparam int TILE_DIM = 8;  // Words per line, lines per tile.
    localparam int WORD_W   = 32; // One matrix element.

    // One memory beat carries exactly one tile line.
    localparam int LINE_W   = TILE_DIM * WORD_W;

    // Byte offset of the first useful byte within a beat.
    localparam int OFFSET_W = $clog2(LINE_W / 8);

    // Line number inside a tile.
    localparam int INDEX_W  = $clog2(TILE_DIM);

    // How a line maps onto the tile.
    // Column mode means the words of one line are one column of the tile.
    localparam logic MODE_COLUMN = 1'b0;
    localparam logic MODE_ROW    = 1'b1;

endpackage

`default_nettype wire

// ==== beat_aligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module beat_aligner (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [tile_pkg::LINE_W-1:0]   beat_data,
    input  logic [tile_pkg::OFFSET_W-1:0] beat_offset,
    input  logic                        beat_dummy,
    input  logic                        beat_valid,
    output logic                        beat_ready,
    output logic [tile_pkg::LINE_W-1:0]   line_data,
    output logic                        line_last,
    output logic                        line_valid,
    input  logic                        line_ready
);

    logic [tile_pkg::LINE_W-1:0]   prev_beat;  // Last accepted beat.
    logic [2*tile_pkg::LINE_W-1:0] window;
    logic [tile_pkg::INDEX_W-1:0]  line_cnt;
    logic                          beat_take;

    // The output register can take a new line when empty or being drained.
    assign beat_ready = ~line_valid | line_ready;
    assign beat_take  = beat_valid & beat_ready;

    // Previous beat holds the low bytes, current beat the high bytes.
    assign window = {beat_data, prev_beat} >> {beat_offset, 3'b000};

    // Payload registers.
    always_ff @(posedge clk) begin
        if (beat_take) begin
            prev_beat <= beat_data;
            if (!beat_dummy) begin
                line_data <= window[tile_pkg::LINE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_valid <= 1'b0;
            line_last  <= 1'b0;
            line_cnt   <= '0;
        end else if (beat_take && !beat_dummy) begin
            line_valid <= 1'b1;
            line_last  <= (line_cnt == tile_pkg::TILE_DIM - 1);
            line_cnt   <= line_cnt + 1'b1;  // Wraps after a full tile.
        end else if (line_ready) begin
            line_valid <= 1'b0;
        end
    end

    // A stalled line must not move under the store.
    a_line_stable : assert property (
        @(posedge clk) disable iff (!rstn)
        line_valid && !line_ready |=> line_valid && $stable(line_data) && $stable(line_last)
    );

endmodule

`default_nettype wire

// ==== tile_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tile_buffer (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         in_mode,
    input  logic [tile_pkg::LINE_W-1:0]  line_data,
    input  logic                         line_last,
    input  logic                         line_valid,
    output logic                         line_ready,
    input  logic                         out_mode,
    input  logic [tile_pkg::INDEX_W-1:0] rd_index,
    output logic [tile_pkg::LINE_W-1:0]  rd_line,
    output logic                         bank_valid,
    input  logic                         bank_release
);

    // Two 8x8 word banks, indexed [bank][row][column].
    logic [tile_pkg::WORD_W-1:0] mem [2][tile_pkg::TILE_DIM][tile_pkg::TILE_DIM];

    logic [1:0]                   wr_ptr;  // Low bit picks the bank.
    logic [1:0]                   rd_ptr;
    logic [tile_pkg::INDEX_W-1:0] wr_cnt;  // Line within the bank being filled.
    logic                         full;
    logic                         empty;
    logic                         wr_en;
    logic                         wr_bank;
    logic                         rd_bank;

    // Wrap bit differs with equal bank bit when both banks hold a tile.
    assign full  = (wr_ptr[1] ^ rd_ptr[1]) & (wr_ptr[0] == rd_ptr[0]);
    assign empty = (wr_ptr == rd_ptr);

    assign line_ready = ~full;
    assign bank_valid = ~empty;

    assign wr_en   = line_valid & line_ready;
    assign wr_bank = wr_ptr[0];
    assign rd_bank = rd_ptr[0];

    // Place the line as a column or a row of the current bank.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < tile_pkg::TILE_DIM; i++) begin
                if (in_mode == tile_pkg::MODE_COLUMN) begin
                    mem[wr_bank][i][wr_cnt] <= line_data[i*tile_pkg::WORD_W +: tile_pkg::WORD_W];
                end else begin
                    mem[wr_bank][wr_cnt][i] <= line_data[i*tile_pkg::WORD_W +: tile_pkg::WORD_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= 2'b00;
            wr_cnt <= '0;
        end else if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (line_last) begin
                wr_ptr <= wr_ptr + 1'b1;  // Bank complete.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= 2'b00;
        end else if (bank_release) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Row or column of the oldest full bank.
    always_comb begin
        for (int i = 0; i < tile_pkg::TILE_DIM; i++) begin
            if (out_mode == tile_pkg::MODE_ROW) begin
                rd_line[i*tile_pkg::WORD_W +: tile_pkg::WORD_W] = mem[rd_bank][rd_index][i];
            end else begin
                rd_line[i*tile_pkg::WORD_W +: tile_pkg::WORD_W] = mem[rd_bank][i][rd_index];
            end
        end
    end

    // Never more than two tiles in flight.
    a_no_overfill : assert property (
        @(posedge clk) disable iff (!rstn)
        (wr_ptr - rd_ptr) <= 2'd2
    );

    // The reader only frees a bank it was told about.
    a_no_release_empty : assert property (
        @(posedge clk) disable iff (!rstn)
        bank_release |-> !empty
    );

    // Aligner's tile boundary must agree with the local line count.
    a_last_at_seven : assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> (line_last == (wr_cnt == tile_pkg::TILE_DIM - 1))
    );

endmodule

`default_nettype wire

// ==== line_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_reader (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         bank_valid,
    output logic [tile_pkg::INDEX_W-1:0] rd_index,
    input  logic [tile_pkg::LINE_W-1:0]  rd_line,
    output logic                         bank_release,
    output logic [tile_pkg::LINE_W-1:0]  out_data,
    output logic                         out_last,
    output logic                         out_valid,
    input  logic                         out_ready
);

    logic [tile_pkg::INDEX_W-1:0] rd_cnt;
    logic                         load;
    logic                         at_last;

    assign rd_index = rd_cnt;
    assign at_last  = (rd_cnt == tile_pkg::TILE_DIM - 1);

    // Fetch a line when a tile is stored and the output slot frees up.
    assign load = bank_valid & (~out_valid | out_ready);

    // The last line is captured here, so the bank can go right away.
    assign bank_release = load & at_last;

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= rd_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            rd_cnt    <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_last  <= at_last;
            rd_cnt    <= rd_cnt + 1'b1;  // Back to line 0 for the next tile.
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Consumer sees a steady line until it takes it.
    a_out_stable : assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
    );

endmodule

`default_nettype wire

// ==== tile_loader_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tile_loader_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [tile_pkg::LINE_W-1:0]   beat_data,
    input  logic [tile_pkg::OFFSET_W-1:0] beat_offset,
    input  logic                          beat_dummy,
    input  logic                          beat_valid,
    output logic                          beat_ready,
    input  logic                          tile_in_mode,   // Source holds it for a whole tile.
    input  logic                          tile_out_mode,
    output logic [tile_pkg::LINE_W-1:0]   out_data,
    output logic                          out_last,
    output logic                          out_valid,
    input  logic                          out_ready
);

    // Aligner to store.
    logic [tile_pkg::LINE_W-1:0]  line_data;
    logic                         line_last;
    logic                         line_valid;
    logic                         line_ready;

    // Store to reader.
    logic [tile_pkg::INDEX_W-1:0] rd_index;
    logic [tile_pkg::LINE_W-1:0]  rd_line;
    logic                         bank_valid;
    logic                         bank_release;

    beat_aligner u_aligner (
        .clk         (clk),
        .rstn        (rstn),
        .beat_data   (beat_data),
        .beat_offset (beat_offset),
        .beat_dummy  (beat_dummy),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .line_data   (line_data),
        .line_last   (line_last),
        .line_valid  (line_valid),
        .line_ready  (line_ready)
    );

    tile_buffer u_store (
        .clk          (clk),
        .rstn         (rstn),
        .in_mode      (tile_in_mode),
        .line_data    (line_data),
        .line_last    (line_last),
        .line_valid   (line_valid),
        .line_ready   (line_ready),
        .out_mode     (tile_out_mode),
        .rd_index     (rd_index),
        .rd_line      (rd_line),
        .bank_valid   (bank_valid),
        .bank_release (bank_release)
    );

    line_reader u_reader (
        .clk          (clk),
        .rstn         (rstn),
        .bank_valid   (bank_valid),
        .rd_index     (rd_index),
        .rd_line      (rd_line),
        .bank_release (bank_release),
        .out_data     (out_data),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

// ==== tb_tile_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tile_loader;

    localparam int TIMEOUT    = 400;  // Cycles allowed for any single wait.
    localparam int BEAT_BYTES = tile_pkg::LINE_W / 8;
    localparam int NUM_BEATS  = tile_pkg::TILE_DIM + 1;  // Priming beat plus one per line.

    logic                          clk = 1'b0;
    logic                          rstn;
    logic [tile_pkg::LINE_W-1:0]   beat_data;
    logic [tile_pkg::OFFSET_W-1:0] beat_offset;
    logic                          beat_dummy;
    logic                          beat_valid;
    logic                          beat_ready;
    logic                          tile_in_mode;
    logic                          tile_out_mode;
    logic [tile_pkg::LINE_W-1:0]   out_data;
    logic                          out_last;
    logic                          out_valid;
    logic                          out_ready = 1'b0;

    logic [tile_pkg::LINE_W-1:0] exp_lines [$];  // Reference model output, in order.
    logic                        exp_lasts [$];
    logic [tile_pkg::LINE_W-1:0] exp_data;
    logic                        exp_last;
    logic                        exp_avail = 1'b0;
    logic                        popped = 1'b0;
    logic                        ready_random = 1'b0;
    logic                        ready_hold = 1'b1;
    logic                        gaps = 1'b0;
    logic [31:0]                 data_rng = 32'h44a6;
    logic [31:0]                 stall_rng = 32'h44a6;
    int                          lines_in = 0;
    int                          lines_start;
    int                          assert_errors = 0;
    int                          other_errors = 0;
    int                          tests = 0;
    int                          test_start = 0;
    int                          waited;

    tile_loader_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Output side stalls, random or held.
    always @(negedge clk) begin
        if (ready_random) begin
            stall_rng = xorshift(stall_rng);
            out_ready <= (stall_rng[1:0] != 2'b00);
        end else begin
            out_ready <= ready_hold;
        end
    end

    always @(posedge clk) begin
        popped <= rstn && out_valid && out_ready;
        if (rstn && beat_valid && beat_ready && !beat_dummy) begin
            lines_in <= lines_in + 1;
        end
    end

    // Queue head moves on the falling edge, so it is steady at the next check.
    always @(negedge clk) begin
        if (popped) begin
            exp_avail = 1'b0;
        end
        if (!exp_avail && exp_lines.size() > 0) begin
            exp_data  = exp_lines.pop_front();
            exp_last  = exp_lasts.pop_front();
            exp_avail = 1'b1;
        end
    end

    a_expected : assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> exp_avail)
        else begin
            $display("%0t: an output line came out when none was expected", $time);
            assert_errors++;
        end

    a_data : assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_avail |-> out_data == exp_data)
        else begin
            $display("FAIL %0t out_data expected %h got %h", $time,
                     $sampled(exp_data), $sampled(out_data));
            assert_errors++;
        end

    a_last : assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_avail |-> out_last == exp_last)
        else begin
            $display("FAIL %0t out_last expected %b got %b", $time,
                     $sampled(exp_last), $sampled(out_last));
            assert_errors++;
        end

    a_stalled : assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> $stable(out_data))
        else begin
            $display("%0t: out_data changed while the consumer was stalling", $time);
            assert_errors++;
        end

    task automatic report_timeout(input string what);
        $display("%0t: timed out waiting for %s", $time, what);
        other_errors++;
    endtask

    // Builds one tile, queues its expected lines and feeds its beats.
    task automatic send_tile(input logic [tile_pkg::OFFSET_W-1:0] off);
        logic [7:0]                  stream [NUM_BEATS*BEAT_BYTES];
        logic [tile_pkg::LINE_W-1:0] beats [NUM_BEATS];
        logic [tile_pkg::LINE_W-1:0] lines [tile_pkg::TILE_DIM];
        logic [tile_pkg::WORD_W-1:0] a [tile_pkg::TILE_DIM][tile_pkg::TILE_DIM];
        logic [tile_pkg::LINE_W-1:0] line;
        int                          idx;
        int                          n;
        for (int i = 0; i < NUM_BEATS * BEAT_BYTES; i++) begin
            data_rng = xorshift(data_rng);
            stream[i] = data_rng[7:0];
        end
        for (int b = 0; b < NUM_BEATS; b++) begin
            for (int j = 0; j < BEAT_BYTES; j++) begin
                beats[b][8*j +: 8] = stream[BEAT_BYTES*b + j];
            end
        end
        // Line k comes with beat k+1: bytes off.. of previous then current beat.
        for (int k = 0; k < tile_pkg::TILE_DIM; k++) begin
            for (int j = 0; j < BEAT_BYTES; j++) begin
                idx = int'(off) + j;
                lines[k][8*j +: 8] = (idx < BEAT_BYTES) ? beats[k][8*idx +: 8]
                                                        : beats[k+1][8*(idx-BEAT_BYTES) +: 8];
            end
        end
        for (int r = 0; r < tile_pkg::TILE_DIM; r++) begin
            for (int c = 0; c < tile_pkg::TILE_DIM; c++) begin
                a[r][c] = (tile_in_mode == tile_pkg::MODE_ROW) ? lines[r][32*c +: 32]
                                                               : lines[c][32*r +: 32];
            end
        end
        for (int k = 0; k < tile_pkg::TILE_DIM; k++) begin
            for (int i = 0; i < tile_pkg::TILE_DIM; i++) begin
                line[32*i +: 32] = (tile_out_mode == tile_pkg::MODE_ROW) ? a[k][i] : a[i][k];
            end
            exp_lines.push_back(line);
            exp_lasts.push_back(k == tile_pkg::TILE_DIM - 1);
        end
        for (int b = 0; b < NUM_BEATS; b++) begin
            if (gaps) begin
                data_rng = xorshift(data_rng);
                repeat (data_rng[1:0]) @(negedge clk);
            end
            beat_data   = beats[b];
            beat_offset = off;
            beat_dummy  = (b == 0);  // First beat only primes the window.
            beat_valid  = 1'b1;
            n = 0;
            while (!beat_ready && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!beat_ready) begin
                report_timeout("beat_ready");
                beat_valid = 1'b0;
                return;
            end
            @(negedge clk);
            beat_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_lines.size() != 0 || exp_avail) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_lines.size() != 0 || exp_avail) begin
            report_timeout("the expected output lines");
        end
        repeat (4) @(negedge clk);  // Room for any extra line to show up.
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = assert_errors + other_errors - test_start;
        tests++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errs);
        end
        test_start = assert_errors + other_errors;
    endtask

    initial begin
        rstn          = 1'b0;
        beat_data     = '0;
        beat_offset   = '0;
        beat_dummy    = 1'b0;
        beat_valid    = 1'b0;
        tile_in_mode  = tile_pkg::MODE_ROW;
        tile_out_mode = tile_pkg::MODE_ROW;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        assert (out_valid == 1'b0) else begin
            $display("FAIL %0t out_valid expected 0 got %b", $time, out_valid);
            other_errors++;
        end
        assert (beat_ready == 1'b1) else begin
            $display("FAIL %0t beat_ready expected 1 got %b", $time, beat_ready);
            other_errors++;
        end
        end_test("idle after reset");

        send_tile(5'd0);
        wait_drained();
        end_test("row in, row out");

        tile_in_mode = tile_pkg::MODE_COLUMN;
        send_tile(5'd0);
        wait_drained();
        end_test("column in, row out");

        tile_in_mode = tile_pkg::MODE_ROW;
        send_tile(5'd13);
        wait_drained();
        end_test("byte offset 13");

        tile_in_mode  = tile_pkg::MODE_COLUMN;
        tile_out_mode = tile_pkg::MODE_COLUMN;
        ready_random  = 1'b1;
        gaps          = 1'b1;
        repeat (3) send_tile(data_rng[tile_pkg::OFFSET_W-1:0]);
        wait_drained();
        ready_random = 1'b0;
        gaps         = 1'b0;
        end_test("random stalls and gaps");

        tile_in_mode  = tile_pkg::MODE_ROW;
        tile_out_mode = tile_pkg::MODE_ROW;
        ready_hold    = 1'b0;
        lines_start   = lines_in;
        fork
            repeat (3) send_tile(5'd7);
            begin
                waited = 0;
                while (beat_ready && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (beat_ready) begin
                    report_timeout("beat_ready to drop with both banks full");
                end
                assert (lines_in - lines_start >= 2 * tile_pkg::TILE_DIM) else begin
                    $display("%0t: beat_ready dropped before two tiles were stored", $time);
                    other_errors++;
                end
                repeat (20) @(negedge clk);
                ready_hold = 1'b1;  // Let the stored tiles drain.
            end
        join
        wait_drained();
        end_test("three tiles under back-pressure");

        $display("%0d tests, %0d errors", tests, assert_errors + other_errors);
        if (assert_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
tile_pkg.sv
beat_aligner.sv
tile_buffer.sv
line_reader.sv
tile_loader_top.sv
tb_tile_loader.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_tile_loader \
    -f sources.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_tile_loader > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
